// File: lineSpriteEval.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module lineSpriteEval import spritePkg::*; (
    input logic clk,
    input logic rstN,
    input logic lineStart,
    input logic [`POS_BIT-1:0] lineY,
    input spriteAttr_t rdData,
    output logic [$clog2(`SPRITE_NUM)-1:0] rdAddr,
    output slot_t slots [`SLOT_NUM]
);

    localparam int SlotBit = $clog2(`SLOT_NUM);

    evalState_t state;
    logic checkPending;
    logic [`POS_BIT-1:0] targetLine;
    logic [`POS_BIT-1:0] nextLine;
    logic [`POS_BIT-1:0] lineOffset;
    logic covers;
    logic [SlotBit:0] fillCnt;
    logic frontSel;
    slot_t slotBuf [2][`SLOT_NUM];

    // evaluation always targets the following line
    assign nextLine = (lineY == `V_TOTAL - 1) ? '0 : lineY + 1'b1;

    // unsigned distance, unused entries never cover
    assign lineOffset = targetLine - rdData.y;
    assign covers = (rdData.y != 8'hFF) && (lineOffset < `TILE_SIZE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= EVAL_IDLE;
            rdAddr <= '0;
            checkPending <= 1'b0;
            targetLine <= '0;
            fillCnt <= '0;
            frontSel <= 1'b0;
            for (int b = 0; b < 2; b++) begin
                for (int s = 0; s < `SLOT_NUM; s++) begin
                    slotBuf[b][s] <= '0;
                end
            end
        end else begin
            // read data lags the address by one cycle
            checkPending <= (state == EVAL_SCAN);
            if (lineStart) begin
                frontSel <= ~frontSel;
                // old front becomes the new back buffer
                for (int s = 0; s < `SLOT_NUM; s++) begin
                    slotBuf[frontSel][s].valid <= 1'b0;
                end
                state <= EVAL_SCAN;
                rdAddr <= '0;
                fillCnt <= '0;
                targetLine <= nextLine;
            end else begin
                case (state)
                    EVAL_SCAN: begin
                        rdAddr <= rdAddr + 1'b1;
                        if (rdAddr == `SPRITE_NUM - 1) begin
                            state <= EVAL_DONE;
                        end
                    end
                    EVAL_DONE: begin
                        // wait for the last entry to be tested
                        if (!checkPending) begin
                            state <= EVAL_IDLE;
                        end
                    end
                    default: begin
                    end
                endcase
                // later hits are dropped once all slots are taken
                if (checkPending && covers && (fillCnt < `SLOT_NUM)) begin
                    slotBuf[~frontSel][fillCnt[SlotBit-1:0]] <= '{valid: 1'b1, attr: rdData};
                    fillCnt <= fillCnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < `SLOT_NUM; s++) begin
            slots[s] = slotBuf[frontSel][s];
        end
    end

    fillLimit: assert property (@(posedge clk) disable iff (!rstN)
        fillCnt <= `SLOT_NUM);

endmodule

// File: ppuChecker.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppuChecker (
    input logic clk,
    input logic rstN,
    input logic hsync,
    input logic vsync,
    input logic [`RGB_BIT-1:0] rgb,
    input logic burstActive,
    output int checkCount,
    output int errCount
);

    localparam int HFall = `H_ACTIVE + `H_FRONT;
    localparam int VFall = `V_ACTIVE + `V_FRONT;
    localparam int HLimit = 2 * `H_TOTAL;
    localparam int VLimit = 2 * `H_TOTAL * `V_TOTAL;

    int x;
    int y;
    int sinceH;
    int sinceV;
    logic hLocked;
    logic vLocked;
    logic armed;
    logic prevH;
    logic prevV;
    logic expH;
    logic expV;
    logic [`RGB_BIT-1:0] expRgb;

    task automatic flagMismatch(input string name, input int expVal, input int actVal);
        errCount++;
        $display("MISMATCH %s x=%0d y=%0d: expected %0h, actual %0h",
                 name, x, y, expVal, actVal);
    endtask

    // registered outputs are stable when sampled at the edge
    always @(posedge clk) begin
        if (!rstN) begin
            x = 0;
            y = 0;
            sinceH = 0;
            sinceV = 0;
            hLocked = 1'b0;
            vLocked = 1'b0;
            armed = 1'b0;
            prevH = 1'b1;
            prevV = 1'b1;
            checkCount = 0;
            errCount = 0;
        end else begin
            // step the rebuilt position, then hold the syncs against it
            x = (x + 1) % `H_TOTAL;
            if (x == 0) begin
                y = (y + 1) % `V_TOTAL;
            end
            expH = !(x >= HFall && x < HFall + `H_SYNC);
            expV = !(y >= VFall && y < VFall + `V_SYNC);
            if (hLocked && hsync !== expH) begin
                flagMismatch("syncPeriod/hsync", expH, hsync);
            end
            if (vLocked && vsync !== expV) begin
                flagMismatch("syncPeriod/vsync", expV, vsync);
            end

            // relock on falling edges
            if (prevH && !hsync) begin
                x = HFall;
                hLocked = 1'b1;
                sinceH = 0;
            end else begin
                sinceH++;
            end
            if (prevV && !vsync) begin
                y = VFall;
                vLocked = 1'b1;
                sinceV = 0;
            end else begin
                sinceV++;
            end
            if (sinceH == HLimit) begin
                $display("hsync falling edge missing for %0d clocks", HLimit);
                errCount++;
            end
            if (sinceV == VLimit) begin
                $display("vsync falling edge missing for %0d clocks", VLimit);
                errCount++;
            end

            // compare from the first full frame after a write burst
            if (burstActive) begin
                armed = 1'b0;
            end else if (hLocked && vLocked && x == 0 && y == 0) begin
                armed = 1'b1;
            end
            if (armed) begin
                expRgb = ppuTb.expectedColor(x, y);
                checkCount++;
                if (rgb !== expRgb) begin
                    flagMismatch(ppuTb.testName, expRgb, rgb);
                end
            end
            prevH = hsync;
            prevV = vsync;
        end
    end

endmodule

// File: ppuTb.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppuTb import spritePkg::*; ();

    localparam int WaitLimit = 2 * `H_TOTAL * `V_TOTAL;

    logic clk;
    logic rstN;
    hostWrite_t cpuWr;
    logic hsync;
    logic vsync;
    logic [`RGB_BIT-1:0] rgb;
    logic burstActive;
    logic timedOut;
    int checkCount;
    int errCount;
    int seed;
    string testName;
    spriteAttr_t shadow [`SPRITE_NUM];

    ppuTop UUT (.*);

    ppuChecker uChecker (.*);

    always #10 clk = ~clk;

    function automatic spriteAttr_t makeSprite(input int sy, input int sx,
                                               input int tile, input int color);
        return '{y: sy[7:0], x: sx[7:0], tile: tile[3:0], color: color[11:0]};
    endfunction

    function automatic spriteAttr_t randomSprite();
        int sy;
        sy = {$random(seed)} % 56;
        // a few entries stay unused
        if (sy >= 52) begin
            sy = 255;
        end
        return makeSprite(sy, {$random(seed)} % 72, $random(seed), $random(seed));
    endfunction

    // expected pixel from the first eight covering entries of its line
    // lowest lit index wins
    function automatic logic [`RGB_BIT-1:0] expectedColor(input int px, input int py);
        logic [7:0] dx;
        logic [7:0] dy;
        logic [`RGB_BIT-1:0] pix;
        logic hit;
        int found;
        if (px >= `H_ACTIVE || py >= `V_ACTIVE) begin
            return '0;
        end
        if (px < `GAME_X0 || px >= `GAME_X0 + `GAME_W ||
            py < `GAME_Y0 || py >= `GAME_Y0 + `GAME_H) begin
            return `BORDER_COLOR;
        end
        pix = `BG_COLOR;
        hit = 1'b0;
        found = 0;
        for (int i = 0; i < `SPRITE_NUM && found < `SLOT_NUM; i++) begin
            // unsigned 8-bit distance from the top row
            dy = py[7:0] - shadow[i].y;
            if (shadow[i].y != 8'hFF && dy < `TILE_SIZE) begin
                found++;
                dx = px[7:0] - shadow[i].x;
                if (!hit && dx < `TILE_SIZE &&
                    (int'(shadow[i].tile) + int'(dy) + int'(dx)) % 3 == 0) begin
                    pix = shadow[i].color;
                    hit = 1'b1;
                end
            end
        end
        return pix;
    endfunction

    task automatic waitVsync(input logic level);
        int n;
        n = 0;
        while (!timedOut && vsync !== level && n < WaitLimit) begin
            @(posedge clk);
            n++;
        end
        if (!timedOut && vsync !== level) begin
            $display("timeout: vsync did not go to %0b within %0d clocks", level, WaitLimit);
            timedOut = 1'b1;
        end
    endtask

    task automatic waitFrames(input int n);
        for (int f = 0; f < n; f++) begin
            waitVsync(1'b1);
            waitVsync(1'b0);
        end
    endtask

    // table writes only during vertical blanking
    task automatic startBurst(input string name);
        waitVsync(1'b0);
        @(posedge clk);
        burstActive <= 1'b1;
        testName = name;
    endtask

    task automatic putSprite(input int idx, input spriteAttr_t attr);
        @(posedge clk);
        cpuWr <= '{valid: 1'b1, addr: idx[5:0], data: attr};
        shadow[idx] = attr;
    endtask

    task automatic endBurst();
        @(posedge clk);
        cpuWr <= '0;
        burstActive <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        cpuWr = '0;
        burstActive = 1'b0;
        timedOut = 1'b0;
        seed = 91;
        testName = "emptyTable";
        for (int i = 0; i < `SPRITE_NUM; i++) begin
            shadow[i] = makeSprite(255, 0, 0, 0);
        end
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        // first frame only locks the checker
        waitFrames(3);

        startBurst("singleSprites");
        putSprite(0, makeSprite(10, 20, 1, 12'hF00));
        putSprite(1, makeSprite(20, 4, 2, 12'h0F0));
        putSprite(2, makeSprite(30, 52, 3, 12'h00F));
        putSprite(3, makeSprite(0, 30, 4, 12'hFF0));
        putSprite(4, makeSprite(42, 40, 5, 12'h0FF));
        putSprite(5, makeSprite(47, 12, 6, 12'hF0F));
        endBurst();
        waitFrames(2);

        // tiles chosen so both sprites light the same pixels where they overlap
        startBurst("overlap");
        putSprite(0, makeSprite(20, 24, 0, 12'hA50));
        putSprite(1, makeSprite(22, 27, 2, 12'h5AF));
        for (int i = 2; i < 6; i++) begin
            putSprite(i, makeSprite(255, 0, 0, 0));
        end
        endBurst();
        waitFrames(2);

        startBurst("tenOnLine");
        for (int i = 0; i < 10; i++) begin
            putSprite(i, makeSprite(30, 8 + 5 * i, i, 12'h111 * (i + 1)));
        end
        endBurst();
        waitFrames(2);

        startBurst("randomTable");
        for (int i = 0; i < `SPRITE_NUM; i++) begin
            putSprite(i, randomSprite());
        end
        endBurst();
        waitFrames(3);

        startBurst("randomRewrite");
        for (int i = 0; i < `SPRITE_NUM; i += 4) begin
            putSprite(i, randomSprite());
        end
        endBurst();
        waitFrames(3);

        @(negedge clk);
        $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errCount, timedOut);
        if (errCount == 0 && !timedOut && checkCount > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: ppuTop.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module ppuTop import videoPkg::*, spritePkg::*; (
    input logic clk,
    input logic rstN,
    input hostWrite_t cpuWr,
    output logic hsync,
    output logic vsync,
    output logic [`RGB_BIT-1:0] rgb
);

    scanPos_t pos;
    syncBits_t rasterSync;
    syncBits_t outSync;
    logic lineStart;
    logic [$clog2(`SPRITE_NUM)-1:0] rdAddr;
    spriteAttr_t rdData;
    slot_t slots [`SLOT_NUM];
    logic [6:0] tileAddr [`SLOT_NUM];
    logic [`TILE_SIZE-1:0] tileRow [`SLOT_NUM];
    logic [`SLOT_NUM-1:0] lit;
    logic [`RGB_BIT-1:0] color [`SLOT_NUM];

    spriteAttrRam uSpriteAttrRam (
        .clk    (clk),
        .rstN   (rstN),
        .wr     (cpuWr),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    videoTiming uVideoTiming (
        .clk       (clk),
        .rstN      (rstN),
        .pos       (pos),
        .sync      (rasterSync),
        .lineStart (lineStart)
    );

    // current line in, slots for it come out one line later
    lineSpriteEval uLineSpriteEval (
        .clk       (clk),
        .rstN      (rstN),
        .lineStart (lineStart),
        .lineY     (pos.y),
        .rdData    (rdData),
        .rdAddr    (rdAddr),
        .slots     (slots)
    );

    spriteTileRom uSpriteTileRom (
        .tileAddr (tileAddr),
        .tileRow  (tileRow)
    );

    for (genvar i = 0; i < `SLOT_NUM; i++) begin : gTileDraw
        tileDraw uTileDraw (
            .pos      (pos),
            .slot     (slots[i]),
            .tileRow  (tileRow[i]),
            .tileAddr (tileAddr[i]),
            .lit      (lit[i]),
            .color    (color[i])
        );
    end

    spriteCompositor uSpriteCompositor (
        .clk    (clk),
        .rstN   (rstN),
        .pos    (pos),
        .syncIn (rasterSync),
        .lit    (lit),
        .color  (color),
        .rgb    (rgb),
        .sync   (outSync)
    );

    assign hsync = outSync.hsync;
    assign vsync = outSync.vsync;

endmodule

// File: ppu_consts.svh
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// reduced raster, horizontal in clocks
`define H_ACTIVE 64
`define H_FRONT 8
`define H_SYNC 8
`define H_BACK 16
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical in lines
`define V_ACTIVE 48
`define V_FRONT 2
`define V_SYNC 2
`define V_BACK 2
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// game window inside the active area
`define GAME_X0 8
`define GAME_W 48
`define GAME_Y0 4
`define GAME_H 40

// sprite table and line slots
`define SPRITE_NUM 64
`define SLOT_NUM 8
`define TILE_SIZE 8

`define BG_COLOR 12'h022
`define BORDER_COLOR 12'h000

`define POS_BIT 8
`define RGB_BIT 12

`endif

// File: run.sh
#!/bin/sh
# build and run the PPU testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module ppuTb \
        -f verilog.f -o ppuSim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/ppuSim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: spriteAttrRam.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module spriteAttrRam import spritePkg::*; (
    input logic clk,
    input logic rstN,
    input hostWrite_t wr,
    input logic [$clog2(`SPRITE_NUM)-1:0] rdAddr,
    output spriteAttr_t rdData
);

    spriteAttr_t mem [`SPRITE_NUM];

    // host port writes, evaluator port reads one cycle later
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // every entry starts unused
            for (int i = 0; i < `SPRITE_NUM; i++) begin
                mem[i] <= '{y: 8'hFF, default: '0};
            end
            rdData <= '0;
        end else begin
            if (wr.valid) begin
                mem[wr.addr] <= wr.data;
            end
            rdData <= mem[rdAddr];
        end
    end

endmodule

// File: spriteCompositor.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module spriteCompositor import videoPkg::*; (
    input logic clk,
    input logic rstN,
    input scanPos_t pos,
    input syncBits_t syncIn,
    input logic [`SLOT_NUM-1:0] lit,
    input logic [`RGB_BIT-1:0] color [`SLOT_NUM],
    output logic [`RGB_BIT-1:0] rgb,
    output syncBits_t sync
);

    logic inWindow;
    logic [`RGB_BIT-1:0] pixColor;

    assign inWindow = (pos.x >= `GAME_X0) && (pos.x < `GAME_X0 + `GAME_W) &&
                      (pos.y >= `GAME_Y0) && (pos.y < `GAME_Y0 + `GAME_H);

    always_comb begin
        pixColor = `BG_COLOR;
        // walk downwards so the lowest lit slot wins
        for (int s = `SLOT_NUM - 1; s >= 0; s--) begin
            if (lit[s]) begin
                pixColor = color[s];
            end
        end
        if (!pos.active) begin
            pixColor = '0;
        end else if (!inWindow) begin
            pixColor = `BORDER_COLOR;
        end
    end

    // syncs go through the same stage to stay aligned with rgb
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rgb <= '0;
            sync <= '{hsync: 1'b1, vsync: 1'b1};
        end else begin
            rgb <= pixColor;
            sync <= syncIn;
        end
    end

    rgbKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(rgb));

endmodule

// File: spritePkg.sv
`include "ppu_consts.svh"

package spritePkg;

    // one table entry, y of 255 marks it unused
    typedef struct packed {
        logic [`POS_BIT-1:0] y;
        logic [`POS_BIT-1:0] x;
        logic [3:0] tile;
        logic [`RGB_BIT-1:0] color;
    } spriteAttr_t;

    // single-cycle write strobe from the host
    typedef struct packed {
        logic valid;
        logic [$clog2(`SPRITE_NUM)-1:0] addr;
        spriteAttr_t data;
    } hostWrite_t;

    typedef struct packed {
        logic valid;
        spriteAttr_t attr;
    } slot_t;

    typedef enum logic [1:0] {
        EVAL_IDLE,
        EVAL_SCAN,
        EVAL_DONE
    } evalState_t;

endpackage

// File: spriteTileRom.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module spriteTileRom (
    input logic [6:0] tileAddr [`SLOT_NUM],
    output logic [`TILE_SIZE-1:0] tileRow [`SLOT_NUM]
);

    logic [`TILE_SIZE-1:0] rom [16 * `TILE_SIZE];

    // bit c of row r in tile t lights when t + r + c is a multiple of 3
    function automatic logic [`TILE_SIZE-1:0] tileRule(input logic [3:0] tile,
                                                       input logic [2:0] row);
        logic [`TILE_SIZE-1:0] bits;
        for (int c = 0; c < `TILE_SIZE; c++) begin
            bits[c] = ((int'(tile) + int'(row) + c) % 3) == 0;
        end
        return bits;
    endfunction

    always_comb begin
        for (int a = 0; a < 16 * `TILE_SIZE; a++) begin
            rom[a] = tileRule(a[6:3], a[2:0]);
        end
    end

    // one independent port per slot
    for (genvar p = 0; p < `SLOT_NUM; p++) begin : gPort
        assign tileRow[p] = rom[tileAddr[p]];
    end

endmodule

// File: tileDraw.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module tileDraw import videoPkg::*, spritePkg::*; (
    input scanPos_t pos,
    input slot_t slot,
    input logic [`TILE_SIZE-1:0] tileRow,
    output logic [6:0] tileAddr,
    output logic lit,
    output logic [`RGB_BIT-1:0] color
);

    localparam int TileBit = $clog2(`TILE_SIZE);

    logic [`POS_BIT-1:0] dx;
    logic [`POS_BIT-1:0] dy;
    logic inBox;

    // offsets into the sprite box, wrap makes left/above fail the range test
    assign dx = pos.x - slot.attr.x;
    assign dy = pos.y - slot.attr.y;

    assign inBox = slot.valid && (dx < `TILE_SIZE) && (dy < `TILE_SIZE);

    // tile number on top, row below
    assign tileAddr = {slot.attr.tile, dy[TileBit-1:0]};

    // column 0 is the leftmost pixel
    assign lit = inBox && tileRow[dx[TileBit-1:0]];
    assign color = slot.attr.color;

endmodule

// File: verilog.f
+incdir+.
videoPkg.sv
spritePkg.sv
spriteAttrRam.sv
videoTiming.sv
lineSpriteEval.sv
spriteTileRom.sv
tileDraw.sv
spriteCompositor.sv
ppuTop.sv
ppuChecker.sv
ppuTb.sv

// File: videoPkg.sv
`include "ppu_consts.svh"

package videoPkg;

    // raster position seen by the pixel pipeline
    typedef struct packed {
        logic [`POS_BIT-1:0] x;
        logic [`POS_BIT-1:0] y;
        logic active;
    } scanPos_t;

    // both low active
    typedef struct packed {
        logic hsync;
        logic vsync;
    } syncBits_t;

endpackage

// File: videoTiming.sv
`timescale 1ns/1ps
`include "ppu_consts.svh"

module videoTiming import videoPkg::*; (
    input logic clk,
    input logic rstN,
    output scanPos_t pos,
    output syncBits_t sync,
    output logic lineStart
);

    logic [`POS_BIT-1:0] hCnt;
    logic [`POS_BIT-1:0] vCnt;

    // free running raster counters
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hCnt <= '0;
            vCnt <= '0;
        end else if (hCnt == `H_TOTAL - 1) begin
            hCnt <= '0;
            if (vCnt == `V_TOTAL - 1) begin
                vCnt <= '0;
            end else begin
                vCnt <= vCnt + 1'b1;
            end
        end else begin
            hCnt <= hCnt + 1'b1;
        end
    end

    assign pos.x = hCnt;
    assign pos.y = vCnt;
    assign pos.active = (hCnt < `H_ACTIVE) && (vCnt < `V_ACTIVE);

    // order is active, front porch, sync, back porch
    assign sync.hsync = !((hCnt >= `H_ACTIVE + `H_FRONT) &&
                          (hCnt < `H_ACTIVE + `H_FRONT + `H_SYNC));
    assign sync.vsync = !((vCnt >= `V_ACTIVE + `V_FRONT) &&
                          (vCnt < `V_ACTIVE + `V_FRONT + `V_SYNC));

    assign lineStart = (hCnt == '0);

    // counters wrap before reaching the totals
    countRange: assert property (@(posedge clk) disable iff (!rstN)
        (hCnt < `H_TOTAL) && (vCnt < `V_TOTAL));

endmodule
